// ==== src.f ====
+incdir+include
design/riscv_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/riscv_core.sv
verif/riscv_core_properties.sv
verif/tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_riscv_core -f src.f -o tb_riscv_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_riscv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/tb_riscv_core.sv ====
// testbench for the core: random programs from a fixed seed, reference model, store checks
`timescale 1ns/1ps
`include "riscv_macros.svh"

module tb_riscv_core import riscv_pkg::*; ();

	localparam int PROG_LEN    = 48;
	localparam int BODY_LEN    = PROG_LEN - 8;
	localparam int NUM_TESTS   = 5;
	localparam int WATCHDOG_NS = NUM_TESTS * PROG_LEN * 8 * 2 * 8;

	logic   clk;
	logic   proc_reset;
	logic   mem_stall;
	waddr_t imem_addr;
	word_t  imem_rdata;
	logic   dmem_read;
	logic   dmem_write;
	waddr_t dmem_addr;
	word_t  dmem_wdata;
	word_t  dmem_rdata;

	// memories and model state
	word_t       imem [256];
	word_t       dmem [64];
	word_t       mdl_mem [64];
	word_t       mdl_regs [32];
	logic [63:0] exp_q [$];
	logic [63:0] got_q [$];
	// program fields per slot, kinds 0-5 reg alu, 6-13 imm alu, 14 lw, 15 sw,
	// 16 beq, 17 bne, 18 jal, 19 jalr
	int          kind_a [PROG_LEN];
	int          rd_a [PROG_LEN];
	int          rs1_a [PROG_LEN];
	int          rs2_a [PROG_LEN];
	int          imm_a [PROG_LEN];
	logic        is_target [PROG_LEN + 1];
	logic        stall_en;
	int          err_count;
	int          fail_tests;

	riscv_core riscv_core_inst (
		.clk(clk), .proc_reset(proc_reset), .mem_stall(mem_stall),
		.imem_addr(imem_addr), .imem_rdata(imem_rdata), .dmem_read(dmem_read),
		.dmem_write(dmem_write), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata)
	);

	always #4 clk = ~clk;

	// both memories answer in the same cycle
	assign imem_rdata = imem[imem_addr[7:0]];
	// read data only while a load drives the port
	assign dmem_rdata = dmem_read ? dmem[dmem_addr[5:0]] : '0;

	// data memory pattern mixes every address bit
	function automatic word_t fill_word(int idx);
		return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h0f0f_1234;
	endfunction

	// refill on reset, store monitor otherwise
	always @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= fill_word(i);
			end
		end else if (dmem_write && !mem_stall) begin
			dmem[dmem_addr[5:0]] <= dmem_wdata;
			got_q.push_back({2'b00, dmem_addr, dmem_wdata});
		end
	end

	// ------------------------------
	// instruction encoding
	// ------------------------------
	function automatic word_t encode(int kind, int rd, int rs1, int rs2, int imm);
		logic [4:0]  d;
		logic [4:0]  s1;
		logic [4:0]  s2;
		logic [11:0] i12;
		logic [12:0] b13;
		logic [20:0] j21;
		d   = 5'(rd);
		s1  = 5'(rs1);
		s2  = 5'(rs2);
		i12 = 12'(imm);
		b13 = 13'(imm);
		j21 = 21'(imm);
		case (kind)
			0:  return {7'h00, s2, s1, 3'b000, d, `OPC_OP};
			1:  return {7'h20, s2, s1, 3'b000, d, `OPC_OP};
			2:  return {7'h00, s2, s1, 3'b111, d, `OPC_OP};
			3:  return {7'h00, s2, s1, 3'b110, d, `OPC_OP};
			4:  return {7'h00, s2, s1, 3'b100, d, `OPC_OP};
			5:  return {7'h00, s2, s1, 3'b010, d, `OPC_OP};
			6:  return {i12, s1, 3'b000, d, `OPC_OP_IMM};
			7:  return {i12, s1, 3'b111, d, `OPC_OP_IMM};
			8:  return {i12, s1, 3'b110, d, `OPC_OP_IMM};
			9:  return {i12, s1, 3'b100, d, `OPC_OP_IMM};
			10: return {i12, s1, 3'b010, d, `OPC_OP_IMM};
			11: return {7'h00, i12[4:0], s1, 3'b001, d, `OPC_OP_IMM};
			12: return {7'h00, i12[4:0], s1, 3'b101, d, `OPC_OP_IMM};
			13: return {7'h20, i12[4:0], s1, 3'b101, d, `OPC_OP_IMM};
			14: return {i12, s1, 3'b010, d, `OPC_LOAD};
			15: return {i12[11:5], s2, s1, 3'b010, i12[4:0], `OPC_STORE};
			16: return {b13[12], b13[10:5], s2, s1, 3'b000, b13[4:1], b13[11], `OPC_BRANCH};
			17: return {b13[12], b13[10:5], s2, s1, 3'b001, b13[4:1], b13[11], `OPC_BRANCH};
			18: return {j21[20], j21[10:1], j21[11], j21[19:12], d, `OPC_JAL};
			default: return {i12, s1, 3'b000, d, `OPC_JALR};
		endcase
	endfunction

	function automatic void place(int idx, int kind, int rd, int rs1, int rs2, int imm);
		kind_a[idx] = kind;
		rd_a[idx]   = rd;
		rs1_a[idx]  = rs1;
		rs2_a[idx]  = rs2;
		imm_a[idx]  = imm;
		imem[idx]   = encode(kind, rd, rs1, rs2, imm);
	endfunction

	// mode 0 alu only, 1 load then use, 2 control mix, 3 anything
	function automatic int pick_kind(int mode, int slot);
		case (mode)
			0: return int'($urandom % 14);
			1: return (slot % 2 == 0) ? 14 : int'($urandom % 14);
			2: return ($urandom % 2 == 0) ? int'($urandom % 14) : 16 + int'($urandom % 4);
			default: return int'($urandom % 20);
		endcase
	endfunction

	task automatic build_program(input int mode);
		int i;
		int kind;
		int rd;
		int rs1;
		int rs2;
		int imm;
		int target;
		for (int n = 0; n <= PROG_LEN; n++) begin
			is_target[n] = 1'b0;
		end
		for (int n = 0; n < 256; n++) begin
			imem[n] = `NOP_INSTR;
		end
		i = 0;
		while (i < BODY_LEN) begin
			kind = pick_kind(mode, i);
			// jalr needs a slot for its base and no branch landing on it
			if (kind == 19 && (i + 1 >= BODY_LEN || is_target[i + 1])) begin
				kind = 6;
			end
			rd  = int'($urandom % 8);
			rs1 = int'($urandom % 8);
			rs2 = int'($urandom % 8);
			imm = (kind >= 11 && kind <= 13) ? int'($urandom % 32) : int'($urandom % 4096) - 2048;
			// memory ops address the window from x0
			if (kind == 14 || kind == 15) begin
				rs1 = 0;
				imm = 4 * int'($urandom % 32);
			end
			if (mode == 1 && kind == 14) begin
				rd = 1 + int'($urandom % 7);
			end
			// consumer right behind the load
			if (mode == 1 && i % 2 == 1) begin
				rs1 = rd_a[i - 1];
				rs2 = rd_a[i - 1];
			end
			if (kind >= 16) begin
				target = i + ((kind == 19) ? 2 : 1) + int'($urandom % 4);
				target = (target > BODY_LEN) ? BODY_LEN : target;
				is_target[target] = 1'b1;
				imm = 4 * (target - i);
			end
			if (kind == 19) begin
				// base gets the target, jalr adds one and clears bit 0
				place(i, 6, 1 + int'($urandom % 7), 0, 0, 4 * target);
				i++;
				place(i, 19, rd, rd_a[i - 1], 0, 1);
			end else begin
				place(i, kind, rd, rs1, rs2, imm);
			end
			i++;
		end
		// dump x1-x7 to fixed words, then spin
		for (int r = 1; r < 8; r++) begin
			place(BODY_LEN + r - 1, 15, 0, 0, r, 4 * (47 + r));
		end
		place(PROG_LEN - 1, 18, 0, 0, 0, 0);
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic word_t model_alu(int kind, word_t a, word_t b);
		case (kind)
			0, 6:   return a + b;
			1:      return a - b;
			2, 7:   return a & b;
			3, 8:   return a | b;
			4, 9:   return a ^ b;
			5, 10:  return {31'b0, $signed(a) < $signed(b)};
			11:     return a << b[4:0];
			12:     return a >> b[4:0];
			default: return word_t'($signed(a) >>> b[4:0]);
		endcase
	endfunction

	task automatic run_model();
		int    idx;
		int    next;
		logic  wr;
		word_t a;
		word_t b;
		word_t imm;
		word_t addr;
		word_t result;
		for (int n = 0; n < 64; n++) begin
			mdl_mem[n] = fill_word(n);
		end
		for (int n = 0; n < 32; n++) begin
			mdl_regs[n] = '0;
		end
		exp_q.delete();
		idx = 0;
		// branches only go forward, so the spin slot is always reached
		while (idx != PROG_LEN - 1) begin
			a      = mdl_regs[rs1_a[idx]];
			b      = mdl_regs[rs2_a[idx]];
			imm    = word_t'(imm_a[idx]);
			addr   = (a + imm) >> 2;
			next   = idx + 1;
			wr     = 1'b1;
			result = '0;
			case (kind_a[idx])
				14: result = mdl_mem[addr[5:0]];
				15: begin
					wr = 1'b0;
					mdl_mem[addr[5:0]] = b;
					exp_q.push_back({addr, b});
				end
				16: begin
					wr   = 1'b0;
					next = (a == b) ? idx + imm_a[idx] / 4 : next;
				end
				17: begin
					wr   = 1'b0;
					next = (a != b) ? idx + imm_a[idx] / 4 : next;
				end
				18: begin
					result = word_t'(4 * (idx + 1));
					next   = idx + imm_a[idx] / 4;
				end
				19: begin
					result = word_t'(4 * (idx + 1));
					next   = int'(((a + imm) & ~word_t'(1)) >> 2);
				end
				default: result = model_alu(kind_a[idx], a, (kind_a[idx] < 6) ? b : imm);
			endcase
			if (wr && rd_a[idx] != 0) begin
				mdl_regs[rd_a[idx]] = result;
			end
			idx = next;
		end
	endtask

	// ------------------------------
	// test sequencing
	// ------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
		mem_stall = stall_en && ($urandom % 100 < 30);
	endtask

	task automatic run_test(input int num, input string name, input int mode, input logic stall);
		int errs;
		int base;
		errs = 0;
		build_program(mode);
		run_model();
		stall_en   = 1'b0;
		mem_stall  = 1'b0;
		proc_reset = 1'b1;
		repeat (3) next_cycle();
		proc_reset = 1'b0;
		base = got_q.size();
		if (imem_addr != '0 || dmem_read || dmem_write) begin
			$display("error at %0t ns: test %0d reset state imem_addr %0h read %b write %b",
			         $time, num, imem_addr, dmem_read, dmem_write);
			errs++;
		end
		// first instruction reaches the data port two edges later
		repeat (2) begin
			next_cycle();
			if (dmem_read || dmem_write) begin
				$display("error at %0t ns: test %0d data access before first instruction",
				         $time, num);
				errs++;
			end
		end
		stall_en = stall;
		// done once every store arrived and fetch sits on the spin slot
		while (got_q.size() - base < exp_q.size() || imem_addr != waddr_t'(PROG_LEN - 1)) begin
			next_cycle();
		end
		stall_en  = 1'b0;
		mem_stall = 1'b0;
		if (got_q.size() - base != exp_q.size()) begin
			$display("error at %0t ns: test %0d store count %0d, expected %0d",
			         $time, num, got_q.size() - base, exp_q.size());
			errs++;
		end
		for (int i = 0; i < exp_q.size() && base + i < got_q.size(); i++) begin
			if (got_q[base + i] != exp_q[i]) begin
				$display("error at %0t ns: test %0d store %0d word %0h data %h, expected %0h %h",
				         $time, num, i, got_q[base + i][63:32], got_q[base + i][31:0],
				         exp_q[i][63:32], exp_q[i][31:0]);
				errs++;
			end
		end
		$display("test %0d %s: %0d stores, %0d errors", num, name, exp_q.size(), errs);
		err_count += errs;
		fail_tests += (errs != 0) ? 1 : 0;
	endtask

	initial begin
		void'($urandom(32'h5ea3));
		$timeformat(-9, 0, "", 0);
		clk        = 1'b0;
		proc_reset = 1'b1;
		mem_stall  = 1'b0;
		stall_en   = 1'b0;
		err_count  = 0;
		fail_tests = 0;
		run_test(1, "alu dependencies", 0, 1'b0);
		run_test(2, "load-use", 1, 1'b0);
		run_test(3, "branches and jumps", 2, 1'b0);
		run_test(4, "random stall", 3, 1'b1);
		run_test(5, "reset from a running program", 3, 1'b0);
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d", NUM_TESTS,
		         fail_tests, err_count, riscv_core_inst.props_inst.assert_failures);
		if (err_count == 0 && riscv_core_inst.props_inst.assert_failures == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog sized from program length, cycles per instruction and stall share
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verif/riscv_core_properties.sv ====
// concurrent checks on the core's memory ports, bound into every riscv_core instance
`timescale 1ns/1ps

module riscv_core_properties import riscv_pkg::*; (
	input logic   clk,
	input logic   proc_reset,
	input logic   mem_stall,
	input waddr_t imem_addr,
	input logic   dmem_read,
	input logic   dmem_write,
	input waddr_t dmem_addr,
	input word_t  dmem_wdata
);

	// failure count, read by the testbench at the end
	int assert_failures = 0;

	// one access per cycle on the data port
	no_read_and_write: assert property (@(posedge clk) !(dmem_read && dmem_write))
		else begin
			assert_failures++;
			$error("dmem_read and dmem_write high together");
		end

	// stalled cycle keeps the data port frozen
	stall_holds_port: assert property (@(posedge clk)
		($past(mem_stall) && !$past(proc_reset)) |->
		($stable(dmem_read) && $stable(dmem_write) && $stable(dmem_addr) && $stable(dmem_wdata)))
		else begin
			assert_failures++;
			$error("data port changed during mem_stall");
		end

	// reset leaves an idle port and fetch from zero
	reset_state: assert property (@(posedge clk)
		$past(proc_reset) |-> (!dmem_write && !dmem_read && imem_addr == '0))
		else begin
			assert_failures++;
			$error("port not idle after reset");
		end

endmodule

bind riscv_core riscv_core_properties props_inst (.*);

// ==== design/riscv_core.sv ====
// five-stage core top, connects fetch, decode, execute and result to the word memory ports
`timescale 1ns/1ps

module riscv_core (
	input  logic             clk,
	input  logic             proc_reset,
	input  logic             mem_stall,
	output riscv_pkg::waddr_t imem_addr,
	input  riscv_pkg::word_t  imem_rdata,
	output logic             dmem_read,
	output logic             dmem_write,
	output riscv_pkg::waddr_t dmem_addr,
	output riscv_pkg::word_t  dmem_wdata,
	input  riscv_pkg::word_t  dmem_rdata
);

	// ------------------------------
	// fetch to decode
	// ------------------------------
	riscv_pkg::word_t        id_instr;
	riscv_pkg::word_t        id_pc;
	logic                    load_use_hold;
	// execute back to fetch and decode
	logic                    redirect;
	riscv_pkg::word_t        redirect_pc;
	logic                    ex_is_load;
	riscv_pkg::reg_idx_t     ex_rd;
	// register file read
	riscv_pkg::reg_idx_t     rs1_idx;
	riscv_pkg::reg_idx_t     rs2_idx;
	riscv_pkg::word_t        rs1_data;
	riscv_pkg::word_t        rs2_data;
	// decode/execute register
	riscv_pkg::instr_class_t ex_class;
	riscv_pkg::alu_op_t      ex_alu_op;
	riscv_pkg::reg_idx_t     ex_rs1;
	riscv_pkg::reg_idx_t     ex_rs2;
	riscv_pkg::reg_idx_t     ex_rd_next;
	riscv_pkg::word_t        ex_rs1_val;
	riscv_pkg::word_t        ex_rs2_val;
	riscv_pkg::word_t        ex_imm;
	riscv_pkg::word_t        ex_pc;
	// memory and writeback stages
	riscv_pkg::word_t        mem_result;
	riscv_pkg::reg_idx_t     mem_rd;
	logic                    mem_regwrite;
	logic                    mem_is_load;
	riscv_pkg::word_t        wb_value;
	riscv_pkg::reg_idx_t     wb_rd;
	logic                    wb_regwrite;

	fetch_unit fetch_inst (
		.clk(clk), .proc_reset(proc_reset), .mem_stall(mem_stall),
		.load_use_hold(load_use_hold), .redirect(redirect), .redirect_pc(redirect_pc),
		.imem_rdata(imem_rdata), .imem_addr(imem_addr), .id_instr(id_instr), .id_pc(id_pc)
	);

	decode_stage decode_inst (
		.clk(clk), .proc_reset(proc_reset), .mem_stall(mem_stall), .redirect(redirect),
		.id_instr(id_instr), .id_pc(id_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_is_load(ex_is_load), .ex_rd(ex_rd), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.load_use_hold(load_use_hold), .ex_class(ex_class), .ex_alu_op(ex_alu_op),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd_next(ex_rd_next), .ex_rs1_val(ex_rs1_val),
		.ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm), .ex_pc(ex_pc)
	);

	execute_stage execute_inst (
		.clk(clk), .proc_reset(proc_reset), .mem_stall(mem_stall), .ex_class(ex_class),
		.ex_alu_op(ex_alu_op), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd_next(ex_rd_next),
		.ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm), .ex_pc(ex_pc),
		.wb_value(wb_value), .wb_rd(wb_rd), .wb_regwrite(wb_regwrite),
		.ex_is_load(ex_is_load), .ex_rd(ex_rd), .redirect(redirect), .redirect_pc(redirect_pc),
		.mem_result(mem_result), .mem_rd(mem_rd), .mem_regwrite(mem_regwrite),
		.mem_is_load(mem_is_load), .dmem_read(dmem_read), .dmem_write(dmem_write),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
	);

	result_stage result_inst (
		.clk(clk), .proc_reset(proc_reset), .mem_stall(mem_stall), .mem_result(mem_result),
		.mem_rd(mem_rd), .mem_regwrite(mem_regwrite), .mem_is_load(mem_is_load),
		.dmem_rdata(dmem_rdata), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data),
		.rs2_data(rs2_data), .wb_value(wb_value), .wb_rd(wb_rd), .wb_regwrite(wb_regwrite)
	);

endmodule

// ==== design/result_stage.sv ====
// memory/writeback register, load data select and the architectural register file
`timescale 1ns/1ps
`include "riscv_macros.svh"

module result_stage import riscv_pkg::*; (
	input  logic     clk,
	input  logic     proc_reset,
	input  logic     mem_stall,
	input  word_t    mem_result,
	input  reg_idx_t mem_rd,
	input  logic     mem_regwrite,
	input  logic     mem_is_load,
	input  word_t    dmem_rdata,
	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	output word_t    rs1_data,
	output word_t    rs2_data,
	output word_t    wb_value,
	output reg_idx_t wb_rd,
	output logic     wb_regwrite
);

	word_t regs [`REG_COUNT];
	logic  wb_write;

	// x0 is never written
	assign wb_write = wb_regwrite && (wb_rd != '0);

	// ------------------------------
	// writeback register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			wb_rd       <= '0;
			wb_regwrite <= 1'b0;
		end else if (!mem_stall) begin
			wb_rd       <= mem_rd;
			wb_regwrite <= mem_regwrite;
		end
	end

	// load data arrives combinationally in the memory cycle
	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			wb_value <= mem_is_load ? dmem_rdata : mem_result;
		end
	end

	// architectural registers start at zero
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (!mem_stall && wb_write) begin
			regs[wb_rd] <= wb_value;
		end
	end

	// write-before-read bypass
	assign rs1_data = (wb_write && wb_rd == rs1_idx) ? wb_value : regs[rs1_idx];
	assign rs2_data = (wb_write && wb_rd == rs2_idx) ? wb_value : regs[rs2_idx];

endmodule

// ==== design/execute_stage.sv ====
// forwarding, alu, branch and jump resolution, and the execute/memory register on the data port
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         mem_stall,
	input  instr_class_t ex_class,
	input  alu_op_t      ex_alu_op,
	input  reg_idx_t     ex_rs1,
	input  reg_idx_t     ex_rs2,
	input  reg_idx_t     ex_rd_next,
	input  word_t        ex_rs1_val,
	input  word_t        ex_rs2_val,
	input  word_t        ex_imm,
	input  word_t        ex_pc,
	input  word_t        wb_value,
	input  reg_idx_t     wb_rd,
	input  logic         wb_regwrite,
	output logic         ex_is_load,
	output reg_idx_t     ex_rd,
	output logic         redirect,
	output word_t        redirect_pc,
	output word_t        mem_result,
	output reg_idx_t     mem_rd,
	output logic         mem_regwrite,
	output logic         mem_is_load,
	output logic         dmem_read,
	output logic         dmem_write,
	output waddr_t       dmem_addr,
	output word_t        dmem_wdata
);

	fwd_sel_t fwd_a_sel;
	fwd_sel_t fwd_b_sel;
	word_t    op_a;
	word_t    rs2_fwd;
	word_t    op_b;
	word_t    alu_result;
	word_t    ex_value;
	logic     take_branch;

	// youngest producer first, x0 never forwarded
	// a load still in memory stage waits for the hold bubble
	function automatic fwd_sel_t pick_source(input reg_idx_t idx);
		if (idx != '0 && mem_regwrite && mem_rd == idx && !mem_is_load) begin
			return FWD_MEM;
		end
		if (idx != '0 && wb_regwrite && wb_rd == idx) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// hazard view for decode
	assign ex_is_load = (ex_class == CLASS_LOAD);
	assign ex_rd      = ex_rd_next;

	// ------------------------------
	// operand forwarding
	// ------------------------------
	assign fwd_a_sel = pick_source(ex_rs1);
	assign fwd_b_sel = pick_source(ex_rs2);

	always_comb begin
		case (fwd_a_sel)
			FWD_MEM: op_a = mem_result;
			FWD_WB:  op_a = wb_value;
			default: op_a = ex_rs1_val;
		endcase
		case (fwd_b_sel)
			FWD_MEM: rs2_fwd = mem_result;
			FWD_WB:  rs2_fwd = wb_value;
			default: rs2_fwd = ex_rs2_val;
		endcase
	end

	// register operand for reg ops and compares
	assign op_b = (ex_class inside {CLASS_ALU_REG, CLASS_BRANCH}) ? rs2_fwd : ex_imm;

	// ------------------------------
	// alu
	// ------------------------------
	always_comb begin
		case (ex_alu_op)
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_XOR: alu_result = op_a ^ op_b;
			ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLL: alu_result = op_a << op_b[4:0];
			ALU_SRL: alu_result = op_a >> op_b[4:0];
			ALU_SRA: alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
			default: alu_result = '0;
		endcase
	end

	// zero result means equal, sense flipped for bne
	assign take_branch = (ex_alu_op == ALU_SUB) ? (alu_result == '0) : (alu_result != '0);

	assign redirect = (ex_class == CLASS_BRANCH && take_branch) ||
	                  (ex_class inside {CLASS_JAL, CLASS_JALR});

	// jalr target is rs1+imm with bit 0 cleared
	assign redirect_pc = (ex_class == CLASS_JALR) ? (alu_result & ~word_t'(1)) : (ex_pc + ex_imm);

	// jumps link pc+4
	assign ex_value = (ex_class inside {CLASS_JAL, CLASS_JALR}) ? (ex_pc + word_t'(4)) : alu_result;

	// execute/memory control and data port
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			mem_rd       <= '0;
			mem_regwrite <= 1'b0;
			mem_is_load  <= 1'b0;
			dmem_read    <= 1'b0;
			dmem_write   <= 1'b0;
			dmem_addr    <= '0;
			dmem_wdata   <= '0;
		end else if (!mem_stall) begin
			mem_rd       <= ex_rd_next;
			mem_regwrite <= (ex_rd_next != '0);
			mem_is_load  <= (ex_class == CLASS_LOAD);
			dmem_read    <= (ex_class == CLASS_LOAD);
			dmem_write   <= (ex_class == CLASS_STORE);
			dmem_addr    <= alu_result[$bits(word_t)-1:2];
			dmem_wdata   <= rs2_fwd;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_result <= ex_value;
		end
	end

endmodule

// ==== design/decode_stage.sv ====
// instruction decode, immediate build, load-use detection and the decode/execute register
`timescale 1ns/1ps
`include "riscv_macros.svh"

module decode_stage import riscv_pkg::*; (
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         mem_stall,
	input  logic         redirect,
	input  word_t        id_instr,
	input  word_t        id_pc,
	input  word_t        rs1_data,
	input  word_t        rs2_data,
	input  logic         ex_is_load,
	input  reg_idx_t     ex_rd,
	output reg_idx_t     rs1_idx,
	output reg_idx_t     rs2_idx,
	output logic         load_use_hold,
	output instr_class_t ex_class,
	output alu_op_t      ex_alu_op,
	output reg_idx_t     ex_rs1,
	output reg_idx_t     ex_rs2,
	output reg_idx_t     ex_rd_next,
	output word_t        ex_rs1_val,
	output word_t        ex_rs2_val,
	output word_t        ex_imm,
	output word_t        ex_pc
);

	logic [6:0]   opcode;
	logic [2:0]   funct3;
	logic         funct7_b5;
	instr_class_t id_class;
	alu_op_t      id_alu_op;
	word_t        id_imm;
	logic         uses_rs1;
	logic         uses_rs2;
	logic         writes_rd;

	// ------------------------------
	// field extraction
	// ------------------------------
	assign opcode    = id_instr[6:0];
	assign funct3    = id_instr[14:12];
	assign funct7_b5 = id_instr[30];
	assign rs1_idx   = id_instr[19:15];
	assign rs2_idx   = id_instr[24:20];

	// unknown opcodes fall to nop
	always_comb begin
		case (opcode)
			`OPC_OP:     id_class = CLASS_ALU_REG;
			`OPC_OP_IMM: id_class = CLASS_ALU_IMM;
			`OPC_LOAD:   id_class = CLASS_LOAD;
			`OPC_STORE:  id_class = CLASS_STORE;
			`OPC_BRANCH: id_class = CLASS_BRANCH;
			`OPC_JAL:    id_class = CLASS_JAL;
			`OPC_JALR:   id_class = CLASS_JALR;
			default:     id_class = CLASS_NOP;
		endcase
	end

	// immediate formats, shifts take shamt from the low I bits
	always_comb begin
		case (id_class)
			CLASS_STORE:  id_imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
			CLASS_BRANCH: id_imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
			                        id_instr[30:25], id_instr[11:8], 1'b0};
			CLASS_JAL:    id_imm = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12],
			                        id_instr[20], id_instr[30:21], 1'b0};
			default:      id_imm = {{20{id_instr[31]}}, id_instr[31:20]};
		endcase
	end

	// function fields to alu op
	always_comb begin
		id_alu_op = ALU_ADD;
		case (id_class)
			CLASS_ALU_REG, CLASS_ALU_IMM: begin
				case (funct3)
					3'b000:  id_alu_op = (id_class == CLASS_ALU_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
					3'b001:  id_alu_op = ALU_SLL;
					3'b010:  id_alu_op = ALU_SLT;
					3'b100:  id_alu_op = ALU_XOR;
					3'b101:  id_alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
					3'b110:  id_alu_op = ALU_OR;
					3'b111:  id_alu_op = ALU_AND;
					default: id_alu_op = ALU_ADD;
				endcase
			end
			// beq compares by sub, bne by xor
			CLASS_BRANCH: id_alu_op = funct3[0] ? ALU_XOR : ALU_SUB;
			default:      id_alu_op = ALU_ADD;
		endcase
	end

	// ------------------------------
	// operand use and hazard
	// ------------------------------
	assign uses_rs1  = !(id_class inside {CLASS_NOP, CLASS_JAL});
	assign uses_rs2  = id_class inside {CLASS_ALU_REG, CLASS_STORE, CLASS_BRANCH};
	assign writes_rd = id_class inside {CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LOAD,
	                                    CLASS_JAL, CLASS_JALR};

	// load in execute feeding this instruction
	assign load_use_hold = ex_is_load && (ex_rd != '0) &&
	                       ((uses_rs1 && ex_rd == rs1_idx) || (uses_rs2 && ex_rd == rs2_idx));

	// decode/execute control, bubble on hazard or squash
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			ex_class   <= CLASS_NOP;
			ex_alu_op  <= ALU_ADD;
			ex_rs1     <= '0;
			ex_rs2     <= '0;
			ex_rd_next <= '0;
		end else if (!mem_stall) begin
			if (load_use_hold || redirect) begin
				ex_class   <= CLASS_NOP;
				ex_alu_op  <= ALU_ADD;
				ex_rs1     <= '0;
				ex_rs2     <= '0;
				ex_rd_next <= '0;
			end else begin
				ex_class   <= id_class;
				ex_alu_op  <= id_alu_op;
				// unused sources never match a forward
				ex_rs1     <= uses_rs1 ? rs1_idx : '0;
				ex_rs2     <= uses_rs2 ? rs2_idx : '0;
				ex_rd_next <= writes_rd ? id_instr[11:7] : '0;
			end
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			ex_rs1_val <= rs1_data;
			ex_rs2_val <= rs2_data;
			ex_imm     <= id_imm;
			ex_pc      <= id_pc;
		end
	end

endmodule

// ==== design/fetch_unit.sv ====
// program counter and fetch/decode instruction register, driven by hold and redirect
`timescale 1ns/1ps
`include "riscv_macros.svh"

module fetch_unit import riscv_pkg::*; (
	input  logic   clk,
	input  logic   proc_reset,
	input  logic   mem_stall,
	input  logic   load_use_hold,
	input  logic   redirect,
	input  word_t  redirect_pc,
	input  word_t  imem_rdata,
	output waddr_t imem_addr,
	output word_t  id_instr,
	output word_t  id_pc
);

	word_t pc;

	// word address of the current fetch
	assign imem_addr = pc[$bits(word_t)-1:2];

	// redirect wins over hold, hold wins over sequential fetch
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			pc       <= '0;
			id_instr <= `NOP_INSTR;
		end else if (!mem_stall) begin
			if (redirect) begin
				pc       <= redirect_pc;
				// squash the wrong-path fetch
				id_instr <= `NOP_INSTR;
			end else if (!load_use_hold) begin
				pc       <= pc + word_t'(4);
				id_instr <= imem_rdata;
			end
		end
	end

	// pc of the instruction now in decode
	always_ff @(posedge clk) begin
		if (!mem_stall && (redirect || !load_use_hold)) begin
			id_pc <= pc;
		end
	end

endmodule

// ==== design/riscv_pkg.sv ====
// shared word types and enums for the pipeline stages, imported by each stage module
`include "riscv_macros.svh"

package riscv_pkg;

	// ------------------------------
	// plain word types
	// ------------------------------
	typedef logic [`XLEN-1:0]      word_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`WADDR_W-1:0]   waddr_t;

	// ------------------------------
	// decoded instruction class
	// ------------------------------
	// nop also marks a bubble
	typedef enum logic [2:0] {
		CLASS_NOP,
		CLASS_ALU_REG,
		CLASS_ALU_IMM,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_BRANCH,
		CLASS_JAL,
		CLASS_JALR
	} instr_class_t;

	// alu function, branches reuse sub and xor
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

endpackage

// ==== include/riscv_macros.svh ====
// width and RV32I encoding macros for the core package and the testbench generator
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath widths
`define XLEN       32
`define REG_IDX_W  5
`define REG_COUNT  32
// word address into either memory
`define WADDR_W    30

// addi x0, x0, 0
`define NOP_INSTR  32'h0000_0013

// major opcodes of the kept subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`endif
